/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = issue_tb
FILELIST  = issue_sched.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* hdl/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_start,
  input  alu_pkg::opcode_t  i_op,
  input  alu_pkg::payload_u i_payload,
  input  alu_pkg::data_t    i_a,
  input  alu_pkg::data_t    i_b,
  input  sched_pkg::tag_t   i_dst,
  input  logic              i_done,
  output logic              o_result_valid,
  output sched_pkg::tag_t   o_result_tag,
  output alu_pkg::data_t    o_result_data
);

  import sched_pkg::*;
  import alu_pkg::*;

  opcode_t r_op;
  data_t   r_a;
  data_t   r_b;    // register operand or extended immediate
  tag_t    r_dst;
  logic    r_armed;
  data_t   w_imm;
  data_t   w_result;

  assign w_imm = data_t'(i_payload.imm);  // signed member, so the cast sign-extends

  // ------------------------------
  // operand capture
  // ------------------------------
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      r_op  <= i_op;
      r_a   <= i_a;
      r_b   <= uses_src2(i_op) ? i_b : w_imm;
      r_dst <= i_dst;
    end
  end

  // set while an operation is in flight
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_armed <= 1'b0;
    end else if (i_start) begin
      r_armed <= 1'b1;
    end else if (i_done) begin
      r_armed <= 1'b0;
    end
  end

  // ------------------------------
  // compute, all modulo 2^16
  // ------------------------------
  always_comb begin
    case (r_op)
      ADD, ADDI: w_result = r_a + r_b;
      SUB:       w_result = r_a - r_b;
      AND:       w_result = r_a & r_b;
      XOR:       w_result = r_a ^ r_b;
      MUL:       w_result = r_a * r_b;  // low half of the product
      default:   w_result = '0;
    endcase
  end

  assign o_result_valid = i_done & r_armed;
  assign o_result_tag   = r_dst;
  assign o_result_data  = w_result;

endmodule

/* hdl/alu_pkg.sv */
package alu_pkg;

  // ------------------------------
  // data path
  // ------------------------------
  localparam int DATA_W = 16;

  typedef logic [DATA_W-1:0] data_t;

  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    XOR  = 3'd3,
    ADDI = 3'd4,  // only immediate-format op
    MUL  = 3'd5
  } opcode_t;

  // second operand field, read as a tag or as an immediate
  typedef union packed {
    struct packed {
      logic [7-sched_pkg::TAG_W:0] pad;
      sched_pkg::tag_t             src2;
    } rs;
    logic signed [7:0] imm;  // sign-extended to DATA_W at issue
  } payload_u;

  // ------------------------------
  // execution latency
  // ------------------------------
  localparam int LAT_W = 3;

  localparam logic [LAT_W-1:0] LAT_SHORT = 3'd1;
  localparam logic [LAT_W-1:0] LAT_MUL   = 3'd4;

  function automatic logic [LAT_W-1:0] op_latency(opcode_t op);
    return (op == MUL) ? LAT_MUL : LAT_SHORT;
  endfunction

  function automatic logic uses_src2(opcode_t op);
    return op != ADDI;
  endfunction

endpackage

/* hdl/exec_timer.sv */
`timescale 1ns/1ps

module exec_timer (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_start,
  input  alu_pkg::opcode_t i_op,
  output logic             o_busy,
  output logic             o_done
);

  import alu_pkg::*;

  logic [LAT_W-1:0] r_cnt;  // remaining cycles of the current op

  // ------------------------------
  // latency countdown
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cnt <= '0;
    end else if (i_start) begin
      r_cnt <= op_latency(i_op);
    end else if (r_cnt != '0) begin
      r_cnt <= r_cnt - LAT_W'(1);
    end
  end

  // busy covers the done cycle as well, so the next pick
  // lands in the cycle after the result strobe
  assign o_busy = (r_cnt != '0);
  assign o_done = (r_cnt == LAT_W'(1));  // final cycle

endmodule

/* hdl/issue_entry.sv */
`timescale 1ns/1ps

module issue_entry (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  // dispatch
  input  logic                    i_alloc,
  input  alu_pkg::opcode_t        i_disp_op,
  input  sched_pkg::tag_t         i_disp_src1,
  input  alu_pkg::payload_u       i_disp_payload,
  input  sched_pkg::tag_t         i_disp_dst,
  input  logic                    i_src1_rdy,
  input  logic                    i_src2_rdy,
  // wakeup buses
  input  logic                    i_wake_a_valid,  // external writeback
  input  sched_pkg::tag_t         i_wake_a_tag,
  input  logic                    i_wake_b_valid,  // ALU result
  input  sched_pkg::tag_t         i_wake_b_tag,
  // control
  input  logic                    i_flush,
  input  logic                    i_picked,
  input  logic                    i_done,
  output sched_pkg::entry_state_t o_state,
  output logic                    o_ready,
  output alu_pkg::opcode_t        o_op,
  output alu_pkg::payload_u       o_payload,
  output sched_pkg::tag_t         o_src1,
  output sched_pkg::tag_t         o_dst
);

  import sched_pkg::*;
  import alu_pkg::*;

  entry_state_t r_state;
  entry_state_t w_state_next;
  opcode_t      r_op;
  payload_u     r_payload;
  tag_t         r_src1;
  tag_t         r_dst;
  logic         r_rdy1;
  logic         r_rdy2;
  logic         w_rdy1_next;
  logic         w_rdy2_next;
  logic         w_load;

  // tag seen on either wakeup bus this cycle
  function automatic logic woken(tag_t tag);
    return (i_wake_a_valid && (i_wake_a_tag == tag)) ||
           (i_wake_b_valid && (i_wake_b_tag == tag));
  endfunction

  assign w_load = i_alloc && !i_flush && (r_state == EMPTY);  // flush kills the dispatch too

  // ------------------------------
  // next state and operand ready
  // ------------------------------
  always_comb begin
    w_state_next = r_state;
    w_rdy1_next  = r_rdy1 | woken(r_src1);  // sticky once set
    w_rdy2_next  = r_rdy2 | woken(r_payload.rs.src2);

    case (r_state)
      EMPTY: begin
        if (w_load) begin
          w_state_next = WAIT;
          w_rdy1_next  = i_src1_rdy | woken(i_disp_src1);
          // unused second source counts as ready
          w_rdy2_next  = !uses_src2(i_disp_op) | i_src2_rdy |
                         woken(i_disp_payload.rs.src2);
        end
      end
      WAIT: begin
        if (i_flush) begin
          w_state_next = EMPTY;
        end else if (i_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (i_done) begin
          w_state_next = EMPTY;  // ALU finished, slot is free again
        end
      end
      default: w_state_next = EMPTY;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= EMPTY;
      r_rdy1  <= 1'b0;
      r_rdy2  <= 1'b0;
    end else begin
      r_state <= w_state_next;
      r_rdy1  <= w_rdy1_next;
      r_rdy2  <= w_rdy2_next;
    end
  end

  // instruction fields, captured on dispatch only
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_op      <= i_disp_op;
      r_payload <= i_disp_payload;
      r_src1    <= i_disp_src1;
      r_dst     <= i_disp_dst;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  // nothing is picked in a flush cycle
  assign o_ready   = (r_state == WAIT) && r_rdy1 && r_rdy2 && !i_flush;
  assign o_state   = r_state;
  assign o_op      = r_op;
  assign o_payload = r_payload;
  assign o_src1    = r_src1;
  assign o_dst     = r_dst;

endmodule

/* hdl/issue_select.sv */
`timescale 1ns/1ps

module issue_select (
  input  logic [sched_pkg::NUM_ENTRIES-1:0] i_ready,
  input  logic [sched_pkg::NUM_ENTRIES-1:0] i_empty,
  input  logic                              i_busy,
  output logic [sched_pkg::NUM_ENTRIES-1:0] o_pick,   // one-hot
  output logic [sched_pkg::NUM_ENTRIES-1:0] o_alloc,  // one-hot
  output logic                              o_full
);

  import sched_pkg::*;

  // lowest set bit of req, as a one-hot vector
  function automatic logic [NUM_ENTRIES-1:0] lowest_set(logic [NUM_ENTRIES-1:0] req);
    logic [NUM_ENTRIES-1:0] grant;
    logic                   found;
    grant = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (req[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
    return grant;
  endfunction

  // ------------------------------
  // issue pick
  // ------------------------------
  // single non-pipelined ALU, so nothing goes out while it is busy
  assign o_pick = i_busy ? '0 : lowest_set(i_ready);

  // ------------------------------
  // free slot for dispatch
  // ------------------------------
  assign o_alloc = lowest_set(i_empty);  // gated by the dispatch strobe upstream
  assign o_full  = ~|i_empty;

endmodule

/* hdl/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
  input  logic              i_clk,
  input  logic              i_reset_n,
  // dispatch
  input  logic              i_disp_valid,
  input  alu_pkg::opcode_t  i_disp_op,
  input  sched_pkg::tag_t   i_disp_src1,
  input  alu_pkg::payload_u i_disp_payload,
  input  sched_pkg::tag_t   i_disp_dst,
  // external writeback
  input  logic              i_wb_valid,
  input  sched_pkg::tag_t   i_wb_tag,
  input  alu_pkg::data_t    i_wb_data,
  input  logic              i_flush,
  output logic              o_full,
  // ALU completion
  output logic              o_result_valid,
  output sched_pkg::tag_t   o_result_tag,
  output alu_pkg::data_t    o_result_data
);

  import sched_pkg::*;
  import alu_pkg::*;

  entry_state_t           w_state   [NUM_ENTRIES];
  opcode_t                w_op      [NUM_ENTRIES];
  payload_u               w_payload [NUM_ENTRIES];
  tag_t                   w_src1    [NUM_ENTRIES];
  tag_t                   w_dst     [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] w_ready;
  logic [NUM_ENTRIES-1:0] w_empty;
  logic [NUM_ENTRIES-1:0] w_pick;
  logic [NUM_ENTRIES-1:0] w_alloc;
  logic [NUM_ENTRIES-1:0] w_alloc_gated;

  opcode_t  w_pick_op;
  payload_u w_pick_payload;
  tag_t     w_pick_src1;
  tag_t     w_pick_dst;
  logic     w_start;
  data_t    w_ra_data;
  data_t    w_rb_data;
  logic     w_src1_rdy;
  logic     w_src2_rdy;
  logic     w_busy;
  logic     w_done;

  // ------------------------------
  // dispatch and pick muxes
  // ------------------------------
  assign w_alloc_gated = w_alloc & {NUM_ENTRIES{i_disp_valid}};  // full queue drops it
  assign w_start       = |w_pick;

  always_comb begin
    w_pick_op      = ADD;
    w_pick_payload = '0;
    w_pick_src1    = '0;
    w_pick_dst     = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (w_pick[i]) begin
        w_pick_op      = w_op[i];
        w_pick_payload = w_payload[i];
        w_pick_src1    = w_src1[i];
        w_pick_dst     = w_dst[i];
      end
    end
  end

  // ------------------------------
  // issue queue
  // ------------------------------
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    issue_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_alloc        (w_alloc_gated[i]),
      .i_disp_op      (i_disp_op),
      .i_disp_src1    (i_disp_src1),
      .i_disp_payload (i_disp_payload),
      .i_disp_dst     (i_disp_dst),
      .i_src1_rdy     (w_src1_rdy),
      .i_src2_rdy     (w_src2_rdy),
      .i_wake_a_valid (i_wb_valid),
      .i_wake_a_tag   (i_wb_tag),
      .i_wake_b_valid (o_result_valid),
      .i_wake_b_tag   (o_result_tag),
      .i_flush        (i_flush),
      .i_picked       (w_pick[i]),
      .i_done         (w_done),
      .o_state        (w_state[i]),
      .o_ready        (w_ready[i]),
      .o_op           (w_op[i]),
      .o_payload      (w_payload[i]),
      .o_src1         (w_src1[i]),
      .o_dst          (w_dst[i])
    );
    assign w_empty[i] = (w_state[i] == EMPTY);
  end

  issue_select u_select (
    .i_ready (w_ready),
    .i_empty (w_empty),
    .i_busy  (w_busy),
    .o_pick  (w_pick),
    .o_alloc (w_alloc),
    .o_full  (o_full)
  );

  // ------------------------------
  // execution
  // ------------------------------
  phys_regfile u_regfile (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wa_valid (i_wb_valid),
    .i_wa_tag   (i_wb_tag),
    .i_wa_data  (i_wb_data),
    .i_wb_valid (o_result_valid),
    .i_wb_tag   (o_result_tag),
    .i_wb_data  (o_result_data),
    .i_ra_tag   (w_pick_src1),
    .i_rb_tag   (w_pick_payload.rs.src2),
    .i_rdy_tag1 (i_disp_src1),
    .i_rdy_tag2 (i_disp_payload.rs.src2),
    .o_ra_data  (w_ra_data),
    .o_rb_data  (w_rb_data),
    .o_rdy1     (w_src1_rdy),
    .o_rdy2     (w_src2_rdy)
  );

  exec_timer u_timer (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_start),
    .i_op      (w_pick_op),
    .o_busy    (w_busy),
    .o_done    (w_done)
  );

  alu_exec u_alu (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_start        (w_start),
    .i_op           (w_pick_op),
    .i_payload      (w_pick_payload),
    .i_a            (w_ra_data),
    .i_b            (w_rb_data),
    .i_dst          (w_pick_dst),
    .i_done         (w_done),
    .o_result_valid (o_result_valid),
    .o_result_tag   (o_result_tag),
    .o_result_data  (o_result_data)
  );

endmodule

/* hdl/phys_regfile.sv */
`timescale 1ns/1ps

module phys_regfile (
  input  logic            i_clk,
  input  logic            i_reset_n,
  // write port A, external writeback
  input  logic            i_wa_valid,
  input  sched_pkg::tag_t i_wa_tag,
  input  alu_pkg::data_t  i_wa_data,
  // write port B, ALU result
  input  logic            i_wb_valid,
  input  sched_pkg::tag_t i_wb_tag,
  input  alu_pkg::data_t  i_wb_data,
  // operand reads for the picked entry
  input  sched_pkg::tag_t i_ra_tag,
  input  sched_pkg::tag_t i_rb_tag,
  // ready lookup for the dispatching instruction
  input  sched_pkg::tag_t i_rdy_tag1,
  input  sched_pkg::tag_t i_rdy_tag2,
  output alu_pkg::data_t  o_ra_data,
  output alu_pkg::data_t  o_rb_data,
  output logic            o_rdy1,
  output logic            o_rdy2
);

  import sched_pkg::*;
  import alu_pkg::*;

  data_t                r_regs [NUM_PREGS];
  logic [NUM_PREGS-1:0] r_rdy;

  // port B written last, so the ALU result wins a tag collision
  always_ff @(posedge i_clk) begin
    if (i_wa_valid) r_regs[i_wa_tag] <= i_wa_data;
    if (i_wb_valid) r_regs[i_wb_tag] <= i_wb_data;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rdy <= '0;
    end else begin
      if (i_wa_valid) r_rdy[i_wa_tag] <= 1'b1;
      if (i_wb_valid) r_rdy[i_wb_tag] <= 1'b1;
    end
  end

  assign o_ra_data = r_regs[i_ra_tag];
  assign o_rb_data = r_regs[i_rb_tag];

  // ready bits with same-cycle write bypass
  always_comb begin
    o_rdy1 = r_rdy[i_rdy_tag1] || (i_wa_valid && (i_wa_tag == i_rdy_tag1)) ||
             (i_wb_valid && (i_wb_tag == i_rdy_tag1));
    o_rdy2 = r_rdy[i_rdy_tag2] || (i_wa_valid && (i_wa_tag == i_rdy_tag2)) ||
             (i_wb_valid && (i_wb_tag == i_rdy_tag2));
  end

endmodule

/* hdl/sched_pkg.sv */
package sched_pkg;

  // ------------------------------
  // physical register space
  // ------------------------------
  localparam int TAG_W     = 5;
  localparam int NUM_PREGS = 32;  // one ready bit per tag

  typedef logic [TAG_W-1:0] tag_t;

  // ------------------------------
  // issue queue
  // ------------------------------
  localparam int NUM_ENTRIES = 4;

  // per-entry lifecycle
  // EMPTY  -> free slot, may take a dispatch
  // WAIT   -> holds an instruction, watching wakeups
  // ISSUED -> sent to the ALU, freed on completion
  typedef enum logic [1:0] {
    EMPTY  = 2'd0,
    WAIT   = 2'd1,
    ISSUED = 2'd2
  } entry_state_t;

endpackage

/* issue_sched.f */
hdl/sched_pkg.sv
hdl/alu_pkg.sv
hdl/issue_entry.sv
hdl/issue_select.sv
hdl/exec_timer.sv
hdl/alu_exec.sv
hdl/phys_regfile.sv
hdl/issue_top.sv
verif/issue_tb.sv

/* verif/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb;

  import sched_pkg::*;
  import alu_pkg::*;

  // step kinds
  localparam logic [1:0] K_WB    = 2'd0;
  localparam logic [1:0] K_DISP  = 2'd1;
  localparam logic [1:0] K_FLUSH = 2'd2;
  localparam logic [1:0] K_IDLE  = 2'd3;

  localparam int DRAIN_LIMIT = 40;  // cycles allowed for pending results
  localparam int QUIET_CYCLES = 20;

  typedef struct packed {
    logic [1:0] kind;
    opcode_t    op;
    tag_t       src1;
    logic [7:0] pay;   // second source tag or immediate
    tag_t       dst;   // destination, or written tag for a writeback
    logic [2:0] lat;   // exact result delay, 0 when not checked
    logic       full;  // expected o_full for flush and idle steps
  } step_t;

  typedef struct packed {
    tag_t       tag;
    data_t      data;
    int         start;
    logic [2:0] lat;
  } pend_t;

  logic     clk = 1'b0;
  logic     reset_n;
  logic     disp_valid;
  opcode_t  disp_op;
  tag_t     disp_src1;
  payload_u disp_payload;
  tag_t     disp_dst;
  logic     wb_valid;
  tag_t     wb_tag;
  data_t    wb_data;
  logic     flush;
  logic     full;
  logic     res_valid;
  tag_t     res_tag;
  data_t    res_data;

  step_t       steps [$];
  string       step_names [$];
  pend_t       pend [$];
  string       pend_names [$];
  data_t       ref_regs [NUM_PREGS];
  logic [31:0] lfsr;
  int          cycle;

  always #10 clk = ~clk;

  issue_top DUT (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_disp_valid   (disp_valid),
    .i_disp_op      (disp_op),
    .i_disp_src1    (disp_src1),
    .i_disp_payload (disp_payload),
    .i_disp_dst     (disp_dst),
    .i_wb_valid     (wb_valid),
    .i_wb_tag       (wb_tag),
    .i_wb_data      (wb_data),
    .i_flush        (flush),
    .o_full         (full),
    .o_result_valid (res_valid),
    .o_result_tag   (res_tag),
    .o_result_data  (res_data)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic data_t ref_alu(opcode_t op, data_t a, data_t b, logic [7:0] imm);
    logic [31:0] prod;
    prod = {16'h0000, a} * {16'h0000, b};
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      XOR:     return a ^ b;
      ADDI:    return a + {{8{imm[7]}}, imm};  // 8-bit immediate, sign-extended
      MUL:     return prod[15:0];
      default: return '0;
    endcase
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand16(output data_t v);
    v = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] rpay(tag_t t);
    return {3'b000, t};
  endfunction

  // ------------------------------
  // checking
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // match a result strobe to the oldest pending dispatch with that tag
  task automatic watch_result();
    int idx;
    int delay;
    idx = -1;
    if (res_valid) begin
      for (int i = 0; i < pend.size(); i++) begin
        if (idx < 0 && pend[i].tag == res_tag) begin
          idx = i;
        end
      end
      assert (idx >= 0)
      else fail_run($sformatf("result strobe on tag %0d with no pending dispatch", res_tag));
      assert (idx == 0)
      else fail_run($sformatf("result for tag %0d arrived out of order", res_tag));
      assert (res_data == pend[idx].data)
      else fail_run($sformatf("mismatch %s: expected %h, actual %h",
                              pend_names[idx], pend[idx].data, res_data));
      delay = cycle - pend[idx].start;
      if (pend[idx].lat != 3'd0) begin
        assert (delay == int'(pend[idx].lat))
        else fail_run($sformatf("mismatch %s latency: expected %0d, actual %0d",
                                pend_names[idx], pend[idx].lat, delay));
      end
      pend.delete(idx);
      pend_names.delete(idx);
    end
  endtask

  // one falling edge, outputs are settled here
  task automatic tick();
    @(negedge clk);
    cycle++;
    watch_result();
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    while (pend.size() != 0 && n < DRAIN_LIMIT) begin
      tick();
      n++;
    end
    if (pend.size() != 0) begin
      fail_run($sformatf("timeout in %s: %0d results never arrived", name, pend.size()));
    end
  endtask

  // ------------------------------
  // step application
  // ------------------------------
  task automatic apply_step(input step_t st, input string name);
    data_t d;
    pend_t p;
    case (st.kind)
      K_WB: begin
        rand16(d);
        ref_regs[st.dst] = d;
        wb_valid = 1'b1;
        wb_tag   = st.dst;
        wb_data  = d;
        tick();
        wb_valid = 1'b0;
      end
      K_DISP: begin
        p.tag   = st.dst;
        p.data  = ref_alu(st.op, ref_regs[st.src1], ref_regs[st.pay[4:0]], st.pay);
        p.start = cycle;
        p.lat   = st.lat;
        ref_regs[st.dst] = p.data;  // later consumers read the produced value
        pend.push_back(p);
        pend_names.push_back(name);
        disp_valid   = 1'b1;
        disp_op      = st.op;
        disp_src1    = st.src1;
        disp_payload = st.pay;
        disp_dst     = st.dst;
        tick();
        disp_valid = 1'b0;
        if (st.lat != 3'd0) begin
          drain(name);  // lone op, finish before the next step
        end
      end
      K_FLUSH: begin
        assert (full == st.full)
        else fail_run($sformatf("mismatch %s full: expected %b, actual %b",
                                name, st.full, full));
        flush = 1'b1;
        tick();
        flush = 1'b0;
        // ALU is idle here, so every pending op was still waiting
        pend.delete();
        pend_names.delete();
      end
      default: begin
        drain(name);
        for (int i = 0; i < QUIET_CYCLES; i++) begin
          tick();  // any strobe now has no pending match
        end
        assert (full == st.full)
        else fail_run($sformatf("mismatch %s full: expected %b, actual %b",
                                name, st.full, full));
      end
    endcase
  endtask

  task automatic add_step(input logic [1:0] kind, input opcode_t op, input tag_t src1,
                          input logic [7:0] pay, input tag_t dst, input logic [2:0] lat,
                          input logic exp_full, input string name);
    step_t st;
    st.kind = kind;
    st.op   = op;
    st.src1 = src1;
    st.pay  = pay;
    st.dst  = dst;
    st.lat  = lat;
    st.full = exp_full;
    steps.push_back(st);
    step_names.push_back(name);
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  task automatic build_table();
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd1, 3'd0, 1'b0, "wb r1");
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd2, 3'd0, 1'b0, "wb r2");
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd3, 3'd0, 1'b0, "wb r3");
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd4, 3'd0, 1'b0, "wb r4");
    // lone short ops, two cycles each
    add_step(K_DISP, ADD, 5'd1, rpay(5'd2), 5'd10, 3'd2, 1'b0, "add");
    add_step(K_DISP, SUB, 5'd3, rpay(5'd4), 5'd11, 3'd2, 1'b0, "sub");
    add_step(K_DISP, AND, 5'd1, rpay(5'd3), 5'd12, 3'd2, 1'b0, "and");
    add_step(K_DISP, XOR, 5'd2, rpay(5'd4), 5'd13, 3'd2, 1'b0, "xor");
    add_step(K_DISP, MUL, 5'd1, rpay(5'd2), 5'd14, 3'd5, 1'b0, "mul");
    add_step(K_DISP, ADDI, 5'd3, 8'h35, 5'd15, 3'd2, 1'b0, "addi positive");
    add_step(K_DISP, ADDI, 5'd4, 8'hc8, 5'd16, 3'd2, 1'b0, "addi negative");
    // dependency chain, woken by result broadcast
    add_step(K_DISP, ADD, 5'd1, rpay(5'd2), 5'd20, 3'd0, 1'b0, "chain add");
    add_step(K_DISP, MUL, 5'd20, rpay(5'd3), 5'd21, 3'd0, 1'b0, "chain mul");
    add_step(K_DISP, SUB, 5'd21, rpay(5'd20), 5'd22, 3'd0, 1'b0, "chain sub");
    add_step(K_DISP, XOR, 5'd22, rpay(5'd4), 5'd23, 3'd0, 1'b0, "chain xor");
    add_step(K_IDLE, ADD, 5'd0, 8'h00, 5'd0, 3'd0, 1'b0, "chain drain");
    // fill the queue with unwritten sources, then flush
    add_step(K_DISP, ADD, 5'd24, rpay(5'd25), 5'd26, 3'd0, 1'b0, "killed add");
    add_step(K_DISP, SUB, 5'd25, rpay(5'd24), 5'd27, 3'd0, 1'b0, "killed sub");
    add_step(K_DISP, XOR, 5'd24, rpay(5'd25), 5'd28, 3'd0, 1'b0, "killed xor");
    add_step(K_DISP, ADDI, 5'd24, 8'h7f, 5'd29, 3'd0, 1'b0, "killed addi");
    add_step(K_FLUSH, ADD, 5'd0, 8'h00, 5'd0, 3'd0, 1'b1, "flush");
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd24, 3'd0, 1'b0, "wb r24");
    add_step(K_WB, ADD, 5'd0, 8'h00, 5'd25, 3'd0, 1'b0, "wb r25");
    add_step(K_IDLE, ADD, 5'd0, 8'h00, 5'd0, 3'd0, 1'b0, "flush quiet");
  endtask

  initial begin
    reset_n      = 1'b0;
    disp_valid   = 1'b0;
    disp_op      = ADD;
    disp_src1    = '0;
    disp_payload = '0;
    disp_dst     = '0;
    wb_valid     = 1'b0;
    wb_tag       = '0;
    wb_data      = '0;
    flush        = 1'b0;
    lfsr         = 32'hd52b03b2;
    cycle        = 0;
    for (int i = 0; i < NUM_PREGS; i++) begin
      ref_regs[i] = '0;
    end
    build_table();

    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    assert (!res_valid && !full)
    else fail_run("result strobe or full flag set right after reset");

    foreach (steps[i]) begin
      apply_step(steps[i], step_names[i]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
